//--- source/lsb_pkg.sv
`default_nettype none

package lsb_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int BYTE_LANES = DATA_W / BYTE_W;

    // Byte address, the memory drops the two low bits
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word on the read or write path
    typedef logic [DATA_W-1:0] data_t;

    // One enable bit per byte lane of data_t
    typedef logic [BYTE_LANES-1:0] wstrb_t;

endpackage

`default_nettype wire

//--- source/sramx_if.sv
`timescale 1ns/1ns
`default_nettype none

interface sramx_if;
    import lsb_pkg::*;

    logic   req;
    logic   wr;
    wstrb_t wstrb;
    addr_t  addr;
    data_t  wdata;

    logic   addr_ok;    // Request taken in a cycle with req high
    logic   data_ok;    // One pulse per accepted request, in order
    data_t  rdata;      // Valid with data_ok for reads

    modport master (
        output req,
        output wr,
        output wstrb,
        output addr,
        output wdata,
        input  addr_ok,
        input  data_ok,
        input  rdata
    );

    modport slave (
        input  req,
        input  wr,
        input  wstrb,
        input  addr,
        input  wdata,
        output addr_ok,
        output data_ok,
        output rdata
    );

endinterface

`default_nettype wire

//--- source/load_store_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module load_store_buffer #(
    parameter int BUFFER_LENGTH = 4
) (
    input  logic    clk,
    input  logic    resetn,
    sramx_if.slave  up,
    sramx_if.master down
);
    import lsb_pkg::*;

    localparam int INDEX_BITS = $clog2(BUFFER_LENGTH);

    typedef logic [INDEX_BITS-1:0] index_t;

    index_t head;                           // Next slot to fill
    index_t tail;                           // Oldest queued request
    logic [BUFFER_LENGTH-1:0] slot_free;
    logic [BUFFER_LENGTH-1:0] q_req;        // Entry not yet taken downstream

    logic [BUFFER_LENGTH-1:0] q_wr;
    wstrb_t q_wstrb [BUFFER_LENGTH];
    addr_t  q_addr  [BUFFER_LENGTH];
    data_t  q_wdata [BUFFER_LENGTH];

    logic queue_empty;
    logic slot_ready;
    logic admit;
    logic push;
    logic pop;
    logic wr_ack;                           // Early write acknowledge

    // A free tail slot means nothing is queued
    assign queue_empty = slot_free[tail];
    assign slot_ready  = slot_free[head];

    // Only one kind of request may sit in the queue, so reads never pass writes
    assign admit = slot_ready && (queue_empty || up.wr == q_wr[tail]);
    assign push  = up.req && admit;
    assign pop   = down.data_ok;

    always_ff @(posedge clk) begin
        if (resetn) begin
            head      <= '0;
            tail      <= '0;
            slot_free <= '1;
            q_req     <= '0;
            wr_ack    <= 1'b0;
        end else begin
            wr_ack <= push && up.wr;

            if (push) begin
                head <= head + index_t'(1);
            end
            if (pop) begin
                tail <= tail + index_t'(1);
            end

            for (int i = 0; i < BUFFER_LENGTH; i++) begin
                if (push && head == index_t'(i)) begin
                    slot_free[i] <= 1'b0;
                    // On pass-through the request may already be taken this cycle
                    q_req[i]     <= queue_empty ? !down.addr_ok : 1'b1;
                end else begin
                    if (pop && tail == index_t'(i)) begin
                        slot_free[i] <= 1'b1;
                    end
                    if (tail == index_t'(i) && down.addr_ok) begin
                        q_req[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_wr[head]    <= up.wr;
            q_wstrb[head] <= up.wstrb;
            q_addr[head]  <= up.addr;
            q_wdata[head] <= up.wdata;
        end
    end

    assign up.addr_ok = admit;
    // Writes are acknowledged early, the downstream write response is absorbed
    assign up.data_ok = (!queue_empty && q_wr[tail]) ? wr_ack : down.data_ok;
    assign up.rdata   = down.rdata;

    assign down.req   = queue_empty ? up.req   : q_req[tail];
    assign down.wr    = queue_empty ? up.wr    : q_wr[tail];
    assign down.wstrb = queue_empty ? up.wstrb : q_wstrb[tail];
    assign down.addr  = queue_empty ? up.addr  : q_addr[tail];
    assign down.wdata = queue_empty ? up.wdata : q_wdata[tail];

endmodule

`default_nettype wire

//--- source/sramx_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module sramx_arbiter (
    input  logic            clk,
    input  logic            resetn,
    sramx_if.slave          m0,
    sramx_if.slave          m1,
    output logic            mem_req,
    output logic            mem_wr,
    output lsb_pkg::wstrb_t mem_wstrb,
    output lsb_pkg::addr_t  mem_addr,
    output lsb_pkg::data_t  mem_wdata,
    input  logic            mem_addr_ok,
    input  logic            mem_data_ok,
    input  lsb_pkg::data_t  mem_rdata
);
    logic locked;       // A memory transaction is outstanding
    logic owner;        // Port that owns the outstanding transaction
    logic rr_pri;       // Port that wins the next tie
    logic grant;
    logic accept;

    always_comb begin
        if (locked) begin
            grant = owner;
        end else if (m0.req && m1.req) begin
            grant = rr_pri;
        end else begin
            grant = m1.req;
        end
    end

    // No new request reaches the memory until the current one is answered
    assign mem_req   = !locked && (grant ? m1.req : m0.req);
    assign mem_wr    = grant ? m1.wr    : m0.wr;
    assign mem_wstrb = grant ? m1.wstrb : m0.wstrb;
    assign mem_addr  = grant ? m1.addr  : m0.addr;
    assign mem_wdata = grant ? m1.wdata : m0.wdata;

    assign accept = mem_req && mem_addr_ok;

    always_ff @(posedge clk) begin
        if (resetn) begin
            locked <= 1'b0;
            owner  <= 1'b0;
            rr_pri <= 1'b0;
        end else if (accept) begin
            locked <= 1'b1;
            owner  <= grant;
            rr_pri <= !grant;       // The other port gets the next tie
        end else if (mem_data_ok) begin
            locked <= 1'b0;
        end
    end

    assign m0.addr_ok = !locked && !grant && mem_addr_ok;
    assign m1.addr_ok = !locked && grant && mem_addr_ok;

    // Responses go back only to the port that owns the lock
    assign m0.data_ok = locked && !owner && mem_data_ok;
    assign m1.data_ok = locked && owner && mem_data_ok;

    assign m0.rdata = mem_rdata;
    assign m1.rdata = mem_rdata;

endmodule

`default_nettype wire

//--- source/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sram_model #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            req,
    input  logic            wr,
    input  lsb_pkg::wstrb_t wstrb,
    input  lsb_pkg::addr_t  addr,
    input  lsb_pkg::data_t  wdata,
    output logic            addr_ok,
    output logic            data_ok,
    output lsb_pkg::data_t  rdata
);
    import lsb_pkg::*;

    localparam int WORD_BITS = $clog2(MEM_WORDS);

    data_t mem [MEM_WORDS];

    logic                 pending;      // Response due in this cycle
    logic                 accept;
    logic [WORD_BITS-1:0] word_idx;

    assign word_idx = addr[WORD_BITS+1:2];     // Word addressed, byte offset ignored
    assign addr_ok  = !pending;
    assign data_ok  = pending;
    assign accept   = req && addr_ok;

    always_ff @(posedge clk) begin
        if (resetn) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (wr) begin
                for (int b = 0; b < BYTE_LANES; b++) begin
                    if (wstrb[b]) begin
                        mem[word_idx][BYTE_W*b +: BYTE_W] <= wdata[BYTE_W*b +: BYTE_W];
                    end
                end
            end else begin
                rdata <= mem[word_idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/lsb_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsb_mem_top #(
    parameter int BUFFER_LENGTH = 4,
    parameter int MEM_WORDS     = 256
) (
    input  logic            clk,
    input  logic            resetn,

    input  logic            p0_req,
    input  logic            p0_wr,
    input  lsb_pkg::wstrb_t p0_wstrb,
    input  lsb_pkg::addr_t  p0_addr,
    input  lsb_pkg::data_t  p0_wdata,
    output logic            p0_addr_ok,
    output logic            p0_data_ok,
    output lsb_pkg::data_t  p0_rdata,

    input  logic            p1_req,
    input  logic            p1_wr,
    input  lsb_pkg::wstrb_t p1_wstrb,
    input  lsb_pkg::addr_t  p1_addr,
    input  lsb_pkg::data_t  p1_wdata,
    output logic            p1_addr_ok,
    output logic            p1_data_ok,
    output lsb_pkg::data_t  p1_rdata
);
    sramx_if cpu0_if ();
    sramx_if cpu1_if ();
    sramx_if mem0_if ();
    sramx_if mem1_if ();

    logic            mem_req;
    logic            mem_wr;
    lsb_pkg::wstrb_t mem_wstrb;
    lsb_pkg::addr_t  mem_addr;
    lsb_pkg::data_t  mem_wdata;
    logic            mem_addr_ok;
    logic            mem_data_ok;
    lsb_pkg::data_t  mem_rdata;

    assign cpu0_if.req   = p0_req;
    assign cpu0_if.wr    = p0_wr;
    assign cpu0_if.wstrb = p0_wstrb;
    assign cpu0_if.addr  = p0_addr;
    assign cpu0_if.wdata = p0_wdata;
    assign p0_addr_ok    = cpu0_if.addr_ok;
    assign p0_data_ok    = cpu0_if.data_ok;
    assign p0_rdata      = cpu0_if.rdata;

    assign cpu1_if.req   = p1_req;
    assign cpu1_if.wr    = p1_wr;
    assign cpu1_if.wstrb = p1_wstrb;
    assign cpu1_if.addr  = p1_addr;
    assign cpu1_if.wdata = p1_wdata;
    assign p1_addr_ok    = cpu1_if.addr_ok;
    assign p1_data_ok    = cpu1_if.data_ok;
    assign p1_rdata      = cpu1_if.rdata;

    load_store_buffer #(.BUFFER_LENGTH(BUFFER_LENGTH)) buf0 (
        .clk    (clk),
        .resetn (resetn),
        .up     (cpu0_if.slave),
        .down   (mem0_if.master)
    );

    load_store_buffer #(.BUFFER_LENGTH(BUFFER_LENGTH)) buf1 (
        .clk    (clk),
        .resetn (resetn),
        .up     (cpu1_if.slave),
        .down   (mem1_if.master)
    );

    sramx_arbiter arb0 (
        .clk         (clk),
        .resetn      (resetn),
        .m0          (mem0_if.slave),
        .m1          (mem1_if.slave),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_wstrb   (mem_wstrb),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    sram_model #(.MEM_WORDS(MEM_WORDS)) mem0 (
        .clk     (clk),
        .resetn  (resetn),
        .req     (mem_req),
        .wr      (mem_wr),
        .wstrb   (mem_wstrb),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .addr_ok (mem_addr_ok),
        .data_ok (mem_data_ok),
        .rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

//--- testbench/lsb_mem_chk.sv
`timescale 1ns/1ns
`default_nettype none

module lsb_mem_chk #(
    parameter int BUFFER_LENGTH = 4
) (
    input logic                     clk,
    input logic                     resetn,
    input logic                     up_req,
    input logic                     up_wr,
    input logic                     up_addr_ok,
    input logic                     up_data_ok,
    input logic                     queue_empty,
    input logic [BUFFER_LENGTH-1:0] slot_free,
    input logic [BUFFER_LENGTH-1:0] q_wr
);

    // Early write acknowledge is a fixed one-cycle delay
    write_ack_delay: assert property (@(posedge clk) disable iff (resetn)
        (up_req && up_addr_ok && up_wr) |=> up_data_ok)
        else $error("write accepted without data_ok in the next cycle");

    // Every occupied slot holds the same kind, so any mismatch blocks admission
    same_kind_admit: assert property (@(posedge clk) disable iff (resetn)
        (|(~slot_free & (up_wr ? ~q_wr : q_wr))) |-> !up_addr_ok)
        else $error("request of the other kind admitted while the queue holds entries");

    // An empty queue has nothing left to answer
    no_stray_data_ok: assert property (@(posedge clk) disable iff (resetn)
        (queue_empty && !(up_req && up_addr_ok)) |-> !up_data_ok)
        else $error("data_ok raised while the queue is empty");

endmodule

bind load_store_buffer lsb_mem_chk #(.BUFFER_LENGTH(BUFFER_LENGTH)) chk0 (
    .clk         (clk),
    .resetn      (resetn),
    .up_req      (up.req),
    .up_wr       (up.wr),
    .up_addr_ok  (up.addr_ok),
    .up_data_ok  (up.data_ok),
    .queue_empty (queue_empty),
    .slot_free   (slot_free),
    .q_wr        (q_wr)
);

`default_nettype wire

//--- testbench/lsb_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsb_mem_tb;
    import lsb_pkg::*;

    localparam int BUFFER_LENGTH = 4;
    localparam int MEM_WORDS     = 256;
    localparam int HALF_PERIOD   = 10;
    localparam int WORD_MSB      = $clog2(MEM_WORDS) + 1;
    localparam int TOTAL_REQS    = 192;                     // Sum of all requests in the tests below

    logic   clk;
    logic   resetn;
    logic   p0_req;
    logic   p0_wr;
    wstrb_t p0_wstrb;
    addr_t  p0_addr;
    data_t  p0_wdata;
    logic   p0_addr_ok;
    logic   p0_data_ok;
    data_t  p0_rdata;
    logic   p1_req;
    logic   p1_wr;
    wstrb_t p1_wstrb;
    addr_t  p1_addr;
    data_t  p1_wdata;
    logic   p1_addr_ok;
    logic   p1_data_ok;
    data_t  p1_rdata;

    data_t  ref_mem [MEM_WORDS];
    data_t  exp0_data [$];
    logic   exp0_read [$];
    string  exp0_name [$];
    data_t  exp1_data [$];
    logic   exp1_read [$];
    string  exp1_name [$];
    integer seed;
    int     value_errors;
    int     protocol_errors;

    lsb_mem_top #(.BUFFER_LENGTH(BUFFER_LENGTH), .MEM_WORDS(MEM_WORDS)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = !clk;
    end

    // Writes update the model at issue time, reads return the current word
    function automatic data_t ref_access(input logic wr, input wstrb_t wstrb, input addr_t addr,
                                         input data_t wdata);
        data_t word;
        word = ref_mem[addr[WORD_MSB:2]];
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    word[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            ref_mem[addr[WORD_MSB:2]] = word;
        end
        return word;
    endfunction

    task automatic check_value(input string test_name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %08h, actual %08h", test_name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic drive_port(input int port, input logic req, input logic wr, input wstrb_t wstrb,
                              input addr_t addr, input data_t wdata);
        if (port == 0) begin
            p0_req   = req;
            p0_wr    = wr;
            p0_wstrb = wstrb;
            p0_addr  = addr;
            p0_wdata = wdata;
        end else begin
            p1_req   = req;
            p1_wr    = wr;
            p1_wstrb = wstrb;
            p1_addr  = addr;
            p1_wdata = wdata;
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the handshake
    task automatic issue(input int port, input string name, input logic wr, input wstrb_t wstrb,
                         input addr_t addr, input data_t wdata);
        logic  accepted;
        data_t expected;
        drive_port(port, 1'b1, wr, wstrb, addr, wdata);
        do begin
            #1;
            accepted = (port == 0) ? p0_addr_ok : p1_addr_ok;
            if (accepted) begin
                expected = ref_access(wr, wstrb, addr, wdata);
                if (port == 0) begin
                    exp0_data.push_back(expected);
                    exp0_read.push_back(!wr);
                    exp0_name.push_back(name);
                end else begin
                    exp1_data.push_back(expected);
                    exp1_read.push_back(!wr);
                    exp1_name.push_back(name);
                end
            end
            @(negedge clk);
        end while (!accepted);
    endtask

    task automatic complete(input int port, input data_t rdata);
        data_t expected;
        logic  is_read;
        string name;
        logic  found;
        found = 1'b1;
        if (port == 0 && exp0_data.size() > 0) begin
            expected = exp0_data.pop_front();
            is_read  = exp0_read.pop_front();
            name     = exp0_name.pop_front();
        end else if (port == 1 && exp1_data.size() > 0) begin
            expected = exp1_data.pop_front();
            is_read  = exp1_read.pop_front();
            name     = exp1_name.pop_front();
        end else begin
            found = 1'b0;
            protocol_errors++;
            $display("Port %0d gave a data_ok while no request was outstanding", port);
        end
        if (found && is_read) begin
            check_value(name, expected, rdata);
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (exp0_data.size() + exp1_data.size() > 0 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    // Each port keeps to its own half of memory
    task automatic random_traffic(input int port, input int base_word);
        integer port_seed;
        addr_t  addr;
        port_seed = seed + port;
        for (int i = 0; i < 16; i++) begin
            issue(port, "concurrent", 1'b1, 4'hf, addr_t'((base_word + i) * 4),
                  data_t'($random(port_seed)));
        end
        for (int i = 0; i < 40; i++) begin
            addr = addr_t'((base_word + ($random(port_seed) & 15)) * 4);
            if ($random(port_seed) & 1) begin
                issue(port, "concurrent", 1'b1, wstrb_t'($random(port_seed)), addr,
                      data_t'($random(port_seed)));
            end else begin
                issue(port, "concurrent", 1'b0, 4'h0, addr, '0);
            end
        end
        drive_port(port, 1'b0, 1'b0, '0, '0, '0);
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (!resetn && p0_data_ok) begin
                complete(0, p0_rdata);
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!resetn && p1_data_ok) begin
                complete(1, p1_rdata);
            end
        end
    end

    initial begin
        repeat (TOTAL_REQS * 40 + 200) @(posedge clk);
        $display("Timeout, the requests did not complete within %0d cycles", TOTAL_REQS * 40 + 200);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed            = 19;
        value_errors    = 0;
        protocol_errors = 0;
        resetn          = 1'b1;
        drive_port(0, 1'b0, 1'b0, '0, '0, '0);
        drive_port(1, 1'b0, 1'b0, '0, '0, '0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;

        for (int i = 0; i < 8; i++) begin
            issue(0, "write_read", 1'b1, 4'hf, addr_t'(i * 4), data_t'($random(seed)));
        end
        for (int i = 0; i < 8; i++) begin
            issue(0, "write_read", 1'b0, 4'h0, addr_t'(i * 4), '0);
        end
        drive_port(0, 1'b0, 1'b0, '0, '0, '0);
        drain();

        for (int i = 16; i < 24; i++) begin
            issue(0, "byte_strobe", 1'b1, 4'hf, addr_t'(i * 4), data_t'($random(seed)));
        end
        for (int i = 16; i < 24; i++) begin
            issue(0, "byte_strobe", 1'b1, wstrb_t'($random(seed)), addr_t'(i * 4),
                  data_t'($random(seed)));
        end
        for (int i = 16; i < 24; i++) begin
            issue(0, "byte_strobe", 1'b0, 4'h0, addr_t'(i * 4), '0);
        end
        drive_port(0, 1'b0, 1'b0, '0, '0, '0);
        drain();

        // Twelve writes overrun the four queue slots
        for (int i = 128; i < 140; i++) begin
            issue(1, "burst", 1'b1, 4'hf, addr_t'(i * 4), data_t'($random(seed)));
        end
        for (int i = 128; i < 140; i++) begin
            issue(1, "burst", 1'b0, 4'h0, addr_t'(i * 4), '0);
        end
        drive_port(1, 1'b0, 1'b0, '0, '0, '0);
        drain();

        for (int i = 0; i < 8; i++) begin
            issue(0, "kind_switch", 1'b1, 4'hf, addr_t'(32 * 4), data_t'($random(seed)));
            issue(0, "kind_switch", 1'b0, 4'h0, addr_t'(32 * 4), '0);
        end
        drive_port(0, 1'b0, 1'b0, '0, '0, '0);
        drain();

        fork
            random_traffic(0, 64);
            random_traffic(1, 192);
        join
        drain();

        if (exp0_data.size() + exp1_data.size() > 0) begin
            $display("%0d requests were still outstanding at the end of the run",
                     exp0_data.size() + exp1_data.size());
            protocol_errors++;
        end
        $display("Errors: %0d value mismatches, %0d protocol errors", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lsb_mem.f
source/lsb_pkg.sv
source/sramx_if.sv
source/load_store_buffer.sv
source/sramx_arbiter.sv
source/sram_model.sv
source/lsb_mem_top.sv
testbench/lsb_mem_chk.sv
testbench/lsb_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f lsb_mem.f --top-module lsb_mem_tb \
    --Mdir obj_dir -o lsb_mem_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/lsb_mem_sim > sim.log 2>&1
cat sim.log
grep -q "^Test completed successfully$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }
